// ==== tb.f ====
cpuPkg.sv
cpuCtrlIf.sv
alu.sv
registerFile.sv
programSequencer.sv
busPort.sv
controlFsm.sv
cpu.sv
cpu_asserts.sv
cpu_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= cpu_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert
SIM_ARGS  ?= +verilator+error+limit+100
PASS_TEXT ?= all tests passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// ==== cpu_tb.sv ====
// Testbench for the CPU that loads a generated program into a memory model and checks each write
`timescale 1ns/1ps

module cpu_tb import cpuPkg::*; ();

    localparam int resetCycles = 8;
    localparam int idleCycles = 10;         // CPU must stay in init while run is low
    localparam int haltCycles = 50;         // Watch the halted CPU this long
    localparam int instrCycles = 13;        // Worst case fetch plus execute with margin

    logic        clk, reset, run;
    logic [7:0]  dataIn, dataOut, address;
    logic        addrHigh, addrLow, wrEn, interrupt;

    logic [7:0]  mem [65536];
    logic [7:0]  hiLatch = '0;              // Address bytes latched from the bus
    logic [7:0]  loLatch = '0;
    logic [15:0] expAddr [$];
    logic [7:0]  expData [$];
    logic [31:0] lfsrState = 32'h1650;
    logic [15:0] emitPc, nextResult;
    int          instrCount, cycleLimit;
    int          cycles = 0;

    cpu #(.resetPc(16'h0000)) i_cpu (
        .clk       (clk),
        .reset     (reset),
        .run       (run),
        .dataIn    (dataIn),
        .dataOut   (dataOut),
        .address   (address),
        .addrHigh  (addrHigh),
        .addrLow   (addrLow),
        .wrEn      (wrEn),
        .interrupt (interrupt)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        if (addrHigh)
            hiLatch <= address;
        if (addrLow)
            loLatch <= address;
        if (wrEn)
            mem[{hiLatch, loLatch}] = dataOut;
        cycles <= cycles + 1;
    end

    always @(negedge clk)
        dataIn = mem[{hiLatch, loLatch}];   // Read data from the latched address

    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // Taps 32, 22, 2, 1
    endfunction

    task automatic randomBits(input int count, output logic [7:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsrState = lfsrNext(lfsrState);
            value = {value[6:0], lfsrState[0]};
        end
    endtask

    function automatic logic [7:0] expectedAlu(input opcode_t op, input logic [7:0] a,
            input logic [7:0] b, input logic [2:0] bitIdx);
        case (op)
            ADD:     return a + b;
            SUB:     return a - b;
            INC:     return a + 8'd1;
            DEC:     return a - 8'd1;
            SET:     return a | (8'd1 << bitIdx);
            default: return a & ~(8'd1 << bitIdx);      // RST
        endcase
    endfunction

    task automatic failRun(input string reason);
        $display("%s", reason);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic emitByte(input logic [7:0] value);
        mem[emitPc] = value;
        emitPc = emitPc + 16'd1;
    endtask

    task automatic emitInstr(input opcode_t op, input logic [2:0] low);
        emitByte({op, low});
        instrCount++;
    endtask

    task automatic emitWmlv(input logic [15:0] addr, input logic [7:0] value);
        emitInstr(WMLV, 3'd0);
        emitByte(addr[15:8]);
        emitByte(addr[7:0]);
        emitByte(value);
    endtask

    // Stores go to consecutive result bytes in program order
    task automatic storeReg(input regId_t r, input logic [7:0] expected);
        emitInstr(WMLR, {1'b0, r});
        emitByte(nextResult[15:8]);
        emitByte(nextResult[7:0]);
        expAddr.push_back(nextResult);
        expData.push_back(expected);
        nextResult = nextResult + 16'd1;
    endtask

    task automatic storeImmediate(input logic [7:0] value);
        emitWmlv(nextResult, value);
        expAddr.push_back(nextResult);
        expData.push_back(value);
        nextResult = nextResult + 16'd1;
    endtask

    task automatic loadImmediate(input regId_t r, input logic [7:0] value);
        emitInstr(LDV, {1'b0, r});
        emitByte(value);
    endtask

    task automatic buildProgram();
        opcode_t     aluOps [6] = '{ADD, SUB, INC, DEC, SET, RST};
        logic [7:0]  a, b, r, v;
        logic [15:0] target;
        emitPc = 16'h0000;
        nextResult = 16'h8000;
        instrCount = 0;
        foreach (aluOps[i]) begin
            randomBits(8, a);
            randomBits(8, b);
            randomBits(3, r);
            loadImmediate(regA, a);
            loadImmediate(regB, b);
            emitInstr(aluOps[i], r[2:0]);           // Low bits are the bit index
            storeReg(regA, expectedAlu(aluOps[i], a, b, r[2:0]));
        end
        randomBits(8, v);                           // Chain of register moves
        loadImmediate(regA, v);
        emitInstr(LDB, {1'b0, regA});
        storeReg(regB, v);
        emitInstr(LDC, {1'b0, regB});
        storeReg(regC, v);
        emitInstr(LDD, {1'b0, regC});
        storeReg(regD, v);
        loadImmediate(regA, ~v);
        emitInstr(LDA, {1'b0, regD});
        storeReg(regA, v);
        randomBits(8, v);
        randomBits(8, r);
        mem[{8'h90, r}] = v;                        // Preloaded byte for LDM
        emitInstr(LDM, {1'b0, regC});
        emitByte(8'h90);
        emitByte(r);
        storeReg(regC, v);
        randomBits(8, v);
        storeImmediate(v);
        loadImmediate(regA, 8'h01);
        emitInstr(DEC, 3'd0);                       // Zero flag set
        target = emitPc + 16'd7;                    // Past JPVZ and the marker store
        emitInstr(JPVZ, 3'd0);
        emitByte(target[15:8]);
        emitByte(target[7:0]);
        emitWmlv(16'h81FF, 8'hEE);                  // Skipped when the jump is taken
        randomBits(8, v);
        storeImmediate(v);
        loadImmediate(regA, 8'h05);
        emitInstr(INC, 3'd0);                       // Zero flag clear
        emitInstr(JPVZ, 3'd0);
        emitByte(8'h40);
        emitByte(8'h00);
        randomBits(8, v);
        storeImmediate(v);
        emitInstr(HALT, 3'd0);
        emitWmlv(16'h81FE, 8'hDD);                  // Never runs after halt
        emitPc = 16'h4000;                          // Wrong target of the untaken jump
        emitWmlv(16'h81FD, 8'hCC);
        emitInstr(HALT, 3'd0);
    endtask

    task automatic checkWrite();
        logic [15:0] wrAddr;
        wrAddr = {hiLatch, loLatch};
        assert (expAddr.size() != 0)
            else failRun($sformatf("Unexpected write of %02h to %04h", dataOut, wrAddr));
        assert (wrAddr == expAddr[0])
            else failRun($sformatf("MISMATCH time %0d ns: address expected %04h, got %04h",
                $time, expAddr[0], wrAddr));
        assert (dataOut == expData[0])
            else failRun($sformatf("MISMATCH time %0d ns: dataOut expected %02h, got %02h",
                $time, expData[0], dataOut));
        expAddr.delete(0);
        expData.delete(0);
    endtask

    initial begin
        reset = 1'b1;
        run = 1'b0;
        dataIn = '0;
        for (int i = 0; i < 65536; i++)
            mem[16'(i)] = 8'(i ^ (i >> 8)) ^ 8'h5A;    // Fill depends on both address bytes
        buildProgram();
        cycleLimit = resetCycles + idleCycles + instrCount * instrCycles + haltCycles;
        repeat (resetCycles) @(negedge clk);
        reset = 1'b0;
        repeat (idleCycles) @(negedge clk);
        run = 1'b1;
    end

    always @(negedge clk) begin
        assert (i_cpu.protocolChecks.failCount == 0)
            else failRun("A bus protocol assertion failed");
        if (!reset && wrEn)
            checkWrite();
        if (cycles >= cycleLimit) begin             // Halted CPU is idle by now
            if (interrupt && expAddr.size() == 0) begin
                $display("all tests passed");
                $finish;
            end else begin
                failRun($sformatf(
                    "Run ended at cycle %0d with interrupt %0b and %0d writes missing",
                    cycles, interrupt, expAddr.size()));
            end
        end
    end

endmodule

// ==== cpu_asserts.sv ====
// Bus protocol, reset and halt assertions bound into the CPU top level
`timescale 1ns/1ps

module cpu_asserts (
    input logic clk,
    input logic reset,
    input logic run,
    input logic addrHigh,
    input logic addrLow,
    input logic wrEn,
    input logic interrupt
);

    int   failCount = 0;        // Failed assertions so far
    logic started;              // Run seen since reset
    logic busIdle;

    assign busIdle = !addrHigh && !addrLow && !wrEn;

    always @(posedge clk) begin
        if (reset)
            started <= 1'b0;
        else if (run)
            started <= 1'b1;
    end

    highThenLow: assert property (@(posedge clk) disable iff (reset) addrHigh |=> addrLow)
        else begin
            failCount++;
            $error("Address high byte not followed by the low byte");
        end

    lowAfterHigh: assert property (@(posedge clk) disable iff (reset) addrLow |-> $past(addrHigh))
        else begin
            failCount++;
            $error("Address low byte without a high byte before it");
        end

    oneHot: assert property (@(posedge clk) disable iff (reset)
            $onehot0({addrHigh, addrLow, wrEn}))
        else begin
            failCount++;
            $error("More than one of addrHigh, addrLow and wrEn active");
        end

    idleBeforeRun: assert property (@(posedge clk) disable iff (reset)
            !started |-> busIdle && !interrupt)
        else begin
            failCount++;
            $error("Bus or interrupt active before run");
        end

    haltIdle: assert property (@(posedge clk) disable iff (reset) interrupt |-> busIdle)
        else begin
            failCount++;
            $error("Halted CPU used the bus");
        end

    haltHolds: assert property (@(posedge clk) disable iff (reset) interrupt |=> interrupt)
        else begin
            failCount++;
            $error("Halted CPU dropped interrupt");
        end

endmodule

bind cpu cpu_asserts protocolChecks (
    .clk       (clk),
    .reset     (reset),
    .run       (run),
    .addrHigh  (addrHigh),
    .addrLow   (addrLow),
    .wrEn      (wrEn),
    .interrupt (interrupt)
);

// ==== cpu.sv ====
// Top level of the 8-bit microcoded CPU with its byte-wide multiplexed memory bus
`timescale 1ns/1ps

module cpu import cpuPkg::*; #(
    parameter logic [addrWidth-1:0] resetPc = '0
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 run,
    input  logic [dataWidth-1:0] dataIn,
    output logic [dataWidth-1:0] dataOut,
    output logic [dataWidth-1:0] address,
    output logic                 addrHigh,
    output logic                 addrLow,
    output logic                 wrEn,
    output logic                 interrupt
);

    cpuCtrlIf ctrl ();

    controlFsm fsmInst (
        .clk       (clk),
        .reset     (reset),
        .run       (run),
        .dataIn    (dataIn),
        .interrupt (interrupt),
        .wrEn      (wrEn),
        .ctrl      (ctrl.fsm)
    );

    programSequencer #(
        .resetPc (resetPc)
    ) seqInst (
        .clk    (clk),
        .reset  (reset),
        .dataIn (dataIn),
        .ctrl   (ctrl.sequencer)
    );

    registerFile regsInst (
        .clk    (clk),
        .reset  (reset),
        .dataIn (dataIn),
        .ctrl   (ctrl.regs)
    );

    busPort busInst (
        .clk      (clk),
        .dataIn   (dataIn),
        .address  (address),
        .addrHigh (addrHigh),
        .addrLow  (addrLow),
        .dataOut  (dataOut),
        .ctrl     (ctrl.port)
    );

endmodule

// ==== controlFsm.sv ====
// Instruction register and init/fetch/execute/halt FSM that decodes each microstep
`timescale 1ns/1ps

module controlFsm import cpuPkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 run,
    input  logic [dataWidth-1:0] dataIn,
    output logic                 interrupt,
    output logic                 wrEn,
    cpuCtrlIf.fsm                ctrl
);

    typedef enum logic [1:0] {init, fetch, execute, halt} state_t;

    state_t     state;
    state_t     nextState;
    instrWord_t ir;
    instrWord_t nextIr;
    opcode_t    op;
    logic       loadIr;
    logic       done;              // Last microstep, back to fetch
    logic       lastStep;          // Final step of a memory access instruction
    logic       addrFromCache;     // Address bytes come from the operand cache

    assign op = ir.regForm.op;
    assign interrupt = (state == halt);
    assign lastStep = (op == WMLV) ? (ctrl.step == 4'd8) : (ctrl.step == 4'd6);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= init;
            ir <= '0;
        end else begin
            state <= nextState;
            if (loadIr)
                ir <= nextIr;
        end
    end

    always_comb begin
        nextState = state;
        nextIr = dataIn;
        loadIr = 1'b0;
        done = 1'b0;
        addrFromCache = 1'b0;
        wrEn = 1'b0;
        ctrl.loadPc = 1'b0;
        ctrl.incPc = 1'b0;
        ctrl.skipPc = 1'b0;
        ctrl.clearStep = 1'b0;
        ctrl.incStep = 1'b0;
        ctrl.regLoad = 1'b0;
        ctrl.regDest = ir.regForm.regSel;
        ctrl.regSrc = ir.regForm.regSel;
        ctrl.loadData = 1'b0;
        ctrl.useAlu = 1'b0;
        ctrl.aluOp = (op == RST) ? aluClr : aluOp_t'(op - ADD);    // ADD..SET map in order
        ctrl.bitIndex = ir.bitForm.bitIdx;
        ctrl.loadFlag = 1'b0;
        ctrl.cacheLoad = 1'b0;
        ctrl.cacheSlotSel = slotHigh;
        ctrl.addrEn = 1'b0;
        ctrl.writeFromCache = 1'b0;

        case (state)
            init: begin
                ctrl.clearStep = 1'b1;
                if (run)
                    nextState = fetch;
            end
            fetch: begin
                ctrl.incStep = 1'b1;
                ctrl.addrEn = (ctrl.step < 4'd2);        // PC high, then PC low
                if (ctrl.step == 4'd2) begin
                    loadIr = 1'b1;
                    ctrl.incPc = 1'b1;
                    ctrl.clearStep = 1'b1;
                    nextState = execute;
                end
            end
            execute: begin
                case (op)
                    ADD, SUB, INC, DEC, SET, RST: begin
                        ctrl.regLoad = 1'b1;
                        ctrl.regDest = regA;
                        ctrl.useAlu = 1'b1;
                        ctrl.loadFlag = 1'b1;
                        done = 1'b1;
                    end
                    LDA, LDB, LDC, LDD: begin
                        ctrl.regLoad = 1'b1;
                        ctrl.regDest = regId_t'(op - LDA);   // Destination follows opcode order
                        done = 1'b1;
                    end
                    LDV: begin
                        ctrl.incStep = 1'b1;
                        ctrl.addrEn = (ctrl.step < 4'd2);
                        if (ctrl.step == 4'd2) begin
                            ctrl.regLoad = 1'b1;
                            ctrl.loadData = 1'b1;
                            ctrl.incPc = 1'b1;
                            done = 1'b1;
                        end
                    end
                    LDM, WMLR, WMLV, JPV: begin
                        ctrl.incStep = 1'b1;
                        ctrl.addrEn = 1'b1;
                        case (ctrl.step)
                            4'd1: ctrl.incPc = 1'b1;             // PC to next operand byte
                            4'd2: ctrl.cacheLoad = 1'b1;         // Address high byte
                            4'd3: ctrl.incPc = (op == WMLV);
                            4'd4: begin
                                ctrl.cacheLoad = 1'b1;
                                ctrl.cacheSlotSel = slotLow;
                                addrFromCache = (op != WMLV);
                            end
                            4'd5: addrFromCache = (op != WMLV);
                            4'd6: begin
                                ctrl.cacheLoad = 1'b1;
                                ctrl.cacheSlotSel = slotData;    // WMLV immediate value
                                addrFromCache = 1'b1;
                            end
                            4'd7: addrFromCache = 1'b1;
                            default: ;
                        endcase
                        if (op == JPV && ctrl.step == 4'd4) begin
                            ctrl.cacheLoad = 1'b0;
                            ctrl.addrEn = 1'b0;
                            ctrl.loadPc = 1'b1;                  // Cached high byte, low on dataIn
                            done = 1'b1;
                        end else if (lastStep) begin
                            ctrl.cacheLoad = 1'b0;
                            ctrl.addrEn = 1'b0;
                            ctrl.incPc = 1'b1;
                            ctrl.regLoad = (op == LDM);
                            ctrl.loadData = 1'b1;
                            ctrl.writeFromCache = (op == WMLV);
                            wrEn = (op != LDM);
                            done = 1'b1;
                        end
                    end
                    JPVZ: begin
                        if (ctrl.zero) begin
                            loadIr = 1'b1;
                            nextIr = {JPV, ir.bitForm.bitIdx};  // Continue as a plain jump
                            ctrl.clearStep = 1'b1;
                        end else begin
                            ctrl.skipPc = 1'b1;                 // Step over the target bytes
                            done = 1'b1;
                        end
                    end
                    HALT: nextState = halt;
                    default: done = 1'b1;                       // NOP and unused opcodes
                endcase
            end
            default: ;                                          // Halted until reset
        endcase

        if (done) begin
            ctrl.clearStep = 1'b1;
            nextState = fetch;
        end
        ctrl.busSel = busSel_t'({addrFromCache, ctrl.step[0]});  // Odd steps carry low byte
    end

endmodule

// ==== busPort.sv ====
// Operand cache plus address byte and write data multiplexing for the memory bus
`timescale 1ns/1ps

module busPort import cpuPkg::*; (
    input  logic                 clk,
    input  logic [dataWidth-1:0] dataIn,
    output logic [dataWidth-1:0] address,
    output logic                 addrHigh,
    output logic                 addrLow,
    output logic [dataWidth-1:0] dataOut,
    cpuCtrlIf.port               ctrl
);

    logic [dataWidth-1:0] cache [3];    // Address high, address low, stored value

    always_ff @(posedge clk) begin
        if (ctrl.cacheLoad)
            cache[ctrl.cacheSlotSel] <= dataIn;
    end

    always_comb begin
        case (ctrl.busSel)
            pcHigh:    address = ctrl.pc[addrWidth-1 -: dataWidth];
            pcLow:     address = ctrl.pc[dataWidth-1:0];
            cacheHigh: address = cache[slotHigh];
            default:   address = cache[slotLow];
        endcase
    end

    assign addrHigh = ctrl.addrEn && (ctrl.busSel == pcHigh || ctrl.busSel == cacheHigh);
    assign addrLow = ctrl.addrEn && (ctrl.busSel == pcLow || ctrl.busSel == cacheLow);

    assign dataOut = ctrl.writeFromCache ? cache[slotData] : ctrl.regOut;
    assign ctrl.cachedHigh = cache[slotHigh];

endmodule

// ==== programSequencer.sv ====
// Program counter and microstep counter that time every instruction
`timescale 1ns/1ps

module programSequencer import cpuPkg::*; #(
    parameter logic [addrWidth-1:0] resetPc = '0
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic [dataWidth-1:0] dataIn,
    cpuCtrlIf.sequencer          ctrl
);

    always_ff @(posedge clk) begin
        if (reset)
            ctrl.pc <= resetPc;
        else if (ctrl.loadPc)
            ctrl.pc <= {ctrl.cachedHigh, dataIn};       // Jump target
        else if (ctrl.skipPc)
            ctrl.pc <= ctrl.pc + addrWidth'(2);
        else if (ctrl.incPc)
            ctrl.pc <= ctrl.pc + addrWidth'(1);
    end

    always_ff @(posedge clk) begin
        if (reset || ctrl.clearStep)
            ctrl.step <= '0;
        else if (ctrl.incStep)
            ctrl.step <= ctrl.step + stepWidth'(1);
    end

endmodule

// ==== registerFile.sv ====
// Registers A to D and the zero flag, loaded from a register, the read bus or the ALU
`timescale 1ns/1ps

module registerFile import cpuPkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  logic [dataWidth-1:0] dataIn,
    cpuCtrlIf.regs               ctrl
);

    logic [dataWidth-1:0] regs [4];     // A, B, C, D
    logic [dataWidth-1:0] wrData;
    logic [dataWidth-1:0] aluResult;
    logic                 aluZero;
    logic                 zeroFlag;

    alu aluInst (
        .a        (regs[regA]),
        .b        (regs[regB]),
        .bitIndex (ctrl.bitIndex),
        .op       (ctrl.aluOp),
        .result   (aluResult),
        .zero     (aluZero)
    );

    always_comb begin
        if (ctrl.useAlu)
            wrData = aluResult;
        else if (ctrl.loadData)
            wrData = dataIn;
        else
            wrData = regs[ctrl.regSrc];         // Register to register move
    end

    always_ff @(posedge clk) begin
        if (ctrl.regLoad)
            regs[ctrl.regDest] <= wrData;
    end

    always_ff @(posedge clk) begin
        if (reset)
            zeroFlag <= 1'b0;
        else if (ctrl.loadFlag)
            zeroFlag <= aluZero;
    end

    assign ctrl.zero = zeroFlag;
    assign ctrl.regOut = regs[ctrl.regSrc];     // Store data for WMLR

endmodule

// ==== alu.sv ====
// Combinational ALU for register A with zero detect on the result
`timescale 1ns/1ps

module alu import cpuPkg::*; (
    input  logic [dataWidth-1:0] a,
    input  logic [dataWidth-1:0] b,
    input  logic [2:0]           bitIndex,
    input  aluOp_t               op,
    output logic [dataWidth-1:0] result,
    output logic                 zero
);

    logic [dataWidth-1:0] bitMask;

    assign bitMask = dataWidth'(1) << bitIndex;

    always_comb begin
        case (op)
            aluAdd:  result = a + b;               // All results wrap at 8 bits
            aluSub:  result = a - b;
            aluInc:  result = a + dataWidth'(1);
            aluDec:  result = a - dataWidth'(1);
            aluSet:  result = a | bitMask;
            aluClr:  result = a & ~bitMask;
            default: result = a;
        endcase
    end

    assign zero = (result == '0);

endmodule

// ==== cpuCtrlIf.sv ====
// Control lines from the FSM to the sequencer, register file and bus port, with status back
`timescale 1ns/1ps

interface cpuCtrlIf import cpuPkg::*; ();

    logic                 loadPc;
    logic                 incPc;
    logic                 skipPc;
    logic                 clearStep;
    logic                 incStep;
    logic [addrWidth-1:0] pc;
    logic [stepWidth-1:0] step;

    logic                 regLoad;
    regId_t               regDest;
    regId_t               regSrc;
    logic                 loadData;
    logic                 useAlu;
    aluOp_t               aluOp;
    logic [2:0]           bitIndex;
    logic                 loadFlag;
    logic                 zero;
    logic [dataWidth-1:0] regOut;

    logic                 cacheLoad;
    cacheSlot_t           cacheSlotSel;
    busSel_t              busSel;
    logic                 addrEn;          // An address byte is on the bus this cycle
    logic                 writeFromCache;
    logic [dataWidth-1:0] cachedHigh;      // Jump target high byte

    modport fsm (
        output loadPc, incPc, skipPc, clearStep, incStep,
        output regLoad, regDest, regSrc, loadData, useAlu, aluOp, bitIndex, loadFlag,
        output cacheLoad, cacheSlotSel, busSel, addrEn, writeFromCache,
        input  step, zero
    );
    modport sequencer (
        input  loadPc, incPc, skipPc, clearStep, incStep, cachedHigh,
        output pc, step
    );
    modport regs (
        input  regLoad, regDest, regSrc, loadData, useAlu, aluOp, bitIndex, loadFlag,
        output zero, regOut
    );
    modport port (
        input  cacheLoad, cacheSlotSel, busSel, addrEn, writeFromCache, pc, regOut,
        output cachedHigh
    );

endinterface

// ==== cpuPkg.sv ====
// Widths, opcodes and control encodings shared by the CPU modules and the testbench
package cpuPkg;

    localparam int dataWidth = 8;      // Register and bus width
    localparam int addrWidth = 16;     // Program counter width
    localparam int stepWidth = 4;      // Microstep counter, longest instruction is 9 steps

    typedef enum logic [4:0] {
        NOP  = 5'b00000,
        ADD  = 5'b00001,
        SUB  = 5'b00010,
        INC  = 5'b00011,
        DEC  = 5'b00100,
        SET  = 5'b00101,
        LDA  = 5'b00110,
        LDB  = 5'b00111,
        LDC  = 5'b01000,
        LDD  = 5'b01001,
        LDV  = 5'b01010,               // Operand byte follows
        LDM  = 5'b01011,               // Address high, address low follow
        WMLR = 5'b01100,
        WMLV = 5'b01101,               // Address high, address low, value follow
        JPV  = 5'b01111,
        JPVZ = 5'b10001,
        RST  = 5'b10011,
        HALT = 5'b11111
    } opcode_t;

    typedef enum logic [1:0] {regA, regB, regC, regD} regId_t;

    // One instruction byte, seen either with a register id or with a bit index
    typedef union packed {
        struct packed {
            opcode_t    op;
            logic       spare;         // Call bit on JPV, ignored
            regId_t     regSel;
        } regForm;
        struct packed {
            opcode_t    op;
            logic [2:0] bitIdx;
        } bitForm;
    } instrWord_t;

    typedef enum logic [2:0] {aluAdd, aluSub, aluInc, aluDec, aluSet, aluClr} aluOp_t;

    // Upper bit picks the cache, lower bit picks the low byte
    typedef enum logic [1:0] {pcHigh, pcLow, cacheHigh, cacheLow} busSel_t;

    typedef enum logic [1:0] {slotHigh, slotLow, slotData} cacheSlot_t;

endpackage
